// File: verilog/isaPkg.sv
// Covers only addu, subu, ori, lui, lw, sw, beq and j; any other encoding decodes as a no-op
`default_nettype none

package isaPkg;

    // Register index and instruction field positions
    localparam int regAddrWidth = 5;
    localparam int immWidth = 16;
    localparam int jumpWidth = 26;
    localparam int opcodeLsb = 26;
    localparam int rsLsb = 21;
    localparam int rtLsb = 16;
    localparam int rdLsb = 11;

    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opBeq     = 6'h04,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcodeT;

    // Meaningful only under opSpecial
    typedef enum logic [5:0] {
        fnAddu = 6'h21,
        fnSubu = 6'h23
    } functT;

    typedef enum logic [1:0] {
        aluAdd,
        aluSub,
        aluOr,
        aluLui
    } aluOpT;

endpackage

`default_nettype wire

// File: verilog/pipePkg.sv
// Tnew counts cycles from decode and never exceeds 3 in this subset
`default_nettype none

package pipePkg;

    // Cycles until a result exists, decremented at every stage boundary
    typedef logic [1:0] tnewT;

    localparam tnewT tnewAlu = 2'd2;
    localparam tnewT tnewLoad = 2'd3;

    // How an instruction reads rs and rt
    typedef enum logic [2:0] {
        hzNone,
        hzBranch,
        hzAlu,
        hzAluImm,
        hzLoad,
        hzStore,
        hzJump
    } hazClassT;

endpackage

`default_nettype wire

// File: verilog/pipeLink.sv
// One instruction's state between two stages; writeAddr is zero whenever nothing is written
`default_nettype none

interface pipeLink import isaPkg::*, pipePkg::*; ();
    aluOpT                   aluOp;
    logic                    isLoad;
    logic                    isStore;
    logic                    writes;
    logic [31:0]             pc;
    // Source indices kept for forwarding in later stages
    logic [regAddrWidth-1:0] rsAddr;
    logic [regAddrWidth-1:0] rtAddr;
    logic [31:0]             rsData;
    logic [31:0]             rtData;
    logic [31:0]             imm;
    logic [regAddrWidth-1:0] writeAddr;
    // Upper immediate into execute, result or address out of it
    logic [31:0]             writeData;
    tnewT                    tnew;

    modport src (output aluOp, isLoad, isStore, writes, pc, rsAddr, rtAddr,
                 rsData, rtData, imm, writeAddr, writeData, tnew);
    modport dst (input aluOp, isLoad, isStore, writes, pc, rsAddr, rtAddr,
                 rsData, rtData, imm, writeAddr, writeData, tnew);
endinterface

`default_nettype wire

// File: verilog/fetchStage.sv
// Expects instr to be the word at pc in the same cycle; a taken branch keeps one delay slot
`default_nettype none

module fetchStage #(
    parameter logic [31:0] resetPc = 32'h3000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    input  logic        branchTaken,
    input  logic [31:0] branchTarget,
    input  logic [31:0] instr,
    output logic [31:0] pc,
    output logic [31:0] idInstr,
    output logic [31:0] idPc
);
    logic [31:0] nextPc;

    // Target applies after the delay slot has been fetched
    always_comb begin
        if (stall) begin
            nextPc = pc;
        end else if (branchTaken) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetPc;
            idInstr <= '0;
            idPc <= resetPc;
        end else begin
            pc <= nextPc;
            // Fetch/decode register holds during a stall
            if (!stall) begin
                idInstr <= instr;
                idPc <= pc;
            end
        end
    end

    pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: verilog/decodeStage.sv
// Unknown words become bubbles; beq and j resolve here using results forwarded from memory
`default_nettype none

module decodeStage import isaPkg::*, pipePkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall,
    input  logic [31:0]             idInstr,
    input  logic [31:0]             idPc,
    input  logic [31:0]             rd1,
    input  logic [31:0]             rd2,
    output logic [regAddrWidth-1:0] ra1,
    output logic [regAddrWidth-1:0] ra2,
    output logic                    branchTaken,
    output logic [31:0]             branchTarget,
    output hazClassT                hazClass,
    output logic [regAddrWidth-1:0] rsAddr,
    output logic [regAddrWidth-1:0] rtAddr,
    pipeLink.src                    idEx,
    pipeLink.dst                    exMem
);
    opcodeT                  opcode;
    functT                   funct;
    logic [regAddrWidth-1:0] rdAddr;
    logic [immWidth-1:0]     imm16;
    logic [31:0]             signImm;
    logic [31:0]             extImm;
    logic [31:0]             pcPlus4;
    logic                    memReady;
    logic [31:0]             rsValue;
    logic [31:0]             rtValue;
    aluOpT                   aluOp;
    logic                    isLoad;
    logic                    isStore;
    logic [regAddrWidth-1:0] writeAddr;
    tnewT                    tnew;

    assign opcode = opcodeT'(idInstr[opcodeLsb +: 6]);
    assign funct = functT'(idInstr[5:0]);
    assign rsAddr = idInstr[rsLsb +: regAddrWidth];
    assign rtAddr = idInstr[rtLsb +: regAddrWidth];
    assign rdAddr = idInstr[rdLsb +: regAddrWidth];
    assign imm16 = idInstr[immWidth-1:0];
    assign signImm = {{(32-immWidth){imm16[immWidth-1]}}, imm16};
    assign pcPlus4 = idPc + 32'd4;
    assign ra1 = rsAddr;
    assign ra2 = rtAddr;

    // Finished result in memory wins over the register file
    assign memReady = exMem.tnew == '0 && exMem.writeAddr != '0;
    assign rsValue = (memReady && exMem.writeAddr == rsAddr) ? exMem.writeData : rd1;
    assign rtValue = (memReady && exMem.writeAddr == rtAddr) ? exMem.writeData : rd2;

    always_comb begin
        hazClass = hzNone;
        aluOp = aluAdd;
        isLoad = 1'b0;
        isStore = 1'b0;
        writeAddr = '0;
        extImm = signImm;
        tnew = '0;
        case (opcode)
            opSpecial: begin
                if (funct == fnAddu || funct == fnSubu) begin
                    hazClass = hzAlu;
                    aluOp = (funct == fnSubu) ? aluSub : aluAdd;
                    writeAddr = rdAddr;
                    tnew = tnewAlu;
                end
            end
            opOri: begin
                hazClass = hzAluImm;
                aluOp = aluOr;
                writeAddr = rtAddr;
                extImm = {{(32-immWidth){1'b0}}, imm16};
                tnew = tnewAlu;
            end
            opLui: begin
                hazClass = hzAluImm;
                aluOp = aluLui;
                writeAddr = rtAddr;
                tnew = tnewAlu;
            end
            opLw: begin
                hazClass = hzLoad;
                isLoad = 1'b1;
                writeAddr = rtAddr;
                tnew = tnewLoad;
            end
            opSw: begin
                hazClass = hzStore;
                isStore = 1'b1;
            end
            opBeq: hazClass = hzBranch;
            opJ: hazClass = hzJump;
            default: hazClass = hzNone;
        endcase
    end

    assign branchTaken = (opcode == opJ) || (opcode == opBeq && rsValue == rtValue);
    assign branchTarget = (opcode == opJ) ?
        {pcPlus4[31:28], idInstr[jumpWidth-1:0], 2'b00} :
        pcPlus4 + {signImm[29:0], 2'b00};

    // Bubble on reset or stall
    always_ff @(posedge clk) begin
        if (reset || stall) begin
            idEx.aluOp <= aluAdd;
            idEx.isLoad <= 1'b0;
            idEx.isStore <= 1'b0;
            idEx.writes <= 1'b0;
            idEx.writeAddr <= '0;
            idEx.tnew <= '0;
        end else begin
            idEx.aluOp <= aluOp;
            idEx.isLoad <= isLoad;
            idEx.isStore <= isStore;
            idEx.writes <= writeAddr != '0;
            idEx.writeAddr <= writeAddr;
            idEx.tnew <= (tnew == '0) ? '0 : tnew - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        idEx.pc <= idPc;
        idEx.rsAddr <= rsAddr;
        idEx.rtAddr <= rtAddr;
        idEx.rsData <= rsValue;
        idEx.rtData <= rtValue;
        idEx.imm <= extImm;
        idEx.writeData <= {imm16, {(32-immWidth){1'b0}}};
    end

endmodule

`default_nettype wire

// File: verilog/regFile.sv
// Register 0 stays zero; a write is seen by both read ports in the same cycle
`default_nettype none

module regFile import isaPkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [regAddrWidth-1:0] ra1,
    input  logic [regAddrWidth-1:0] ra2,
    input  logic                    we,
    input  logic [regAddrWidth-1:0] wa,
    input  logic [31:0]             wd,
    output logic [31:0]             rd1,
    output logic [31:0]             rd2
);
    logic [31:0] regs [2**regAddrWidth];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**regAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // Write-through covers the writeback-to-decode gap
    assign rd1 = (we && wa != '0 && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (we && wa != '0 && wa == ra2) ? wd : regs[ra2];

    zeroReads: assert property (@(posedge clk) disable iff (reset)
        (ra1 != '0 || rd1 == '0) && (ra2 != '0 || rd2 == '0));

endmodule

`default_nettype wire

// File: verilog/executeStage.sv
// Forwards only from sources whose tnew is zero; a late load into a store is fixed in memory
`default_nettype none

module executeStage import isaPkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [regAddrWidth-1:0] wbAddr,
    input  logic [31:0]             wbData,
    pipeLink.dst                    idEx,
    pipeLink.src                    exMem
);
    logic        memReady;
    logic [31:0] rsValue;
    logic [31:0] rtValue;
    logic [31:0] operandB;
    logic [31:0] aluResult;

    assign memReady = exMem.tnew == '0 && exMem.writeAddr != '0;

    // Memory first, then writeback, then the value from decode
    always_comb begin
        if (memReady && exMem.writeAddr == idEx.rsAddr) begin
            rsValue = exMem.writeData;
        end else if (wbAddr != '0 && wbAddr == idEx.rsAddr) begin
            rsValue = wbData;
        end else begin
            rsValue = idEx.rsData;
        end
        if (memReady && exMem.writeAddr == idEx.rtAddr) begin
            rtValue = exMem.writeData;
        end else if (wbAddr != '0 && wbAddr == idEx.rtAddr) begin
            rtValue = wbData;
        end else begin
            rtValue = idEx.rtData;
        end
    end

    // Immediate operand for ori and for load/store addresses
    assign operandB = (idEx.isLoad || idEx.isStore || idEx.aluOp == aluOr) ? idEx.imm : rtValue;

    always_comb begin
        case (idEx.aluOp)
            aluSub:  aluResult = rsValue - operandB;
            aluOr:   aluResult = rsValue | operandB;
            aluLui:  aluResult = idEx.writeData;
            default: aluResult = rsValue + operandB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exMem.aluOp <= aluAdd;
            exMem.isLoad <= 1'b0;
            exMem.isStore <= 1'b0;
            exMem.writes <= 1'b0;
            exMem.writeAddr <= '0;
            exMem.tnew <= '0;
        end else begin
            exMem.aluOp <= idEx.aluOp;
            exMem.isLoad <= idEx.isLoad;
            exMem.isStore <= idEx.isStore;
            exMem.writes <= idEx.writes;
            exMem.writeAddr <= idEx.writeAddr;
            exMem.tnew <= (idEx.tnew == '0) ? '0 : idEx.tnew - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        exMem.pc <= idEx.pc;
        exMem.rsAddr <= idEx.rsAddr;
        exMem.rtAddr <= idEx.rtAddr;
        exMem.rsData <= rsValue;
        exMem.rtData <= rtValue;
        exMem.imm <= idEx.imm;
        exMem.writeData <= aluResult;
    end

endmodule

`default_nettype wire

// File: verilog/memoryStage.sv
// Word access only and the bridge always accepts; brRData must answer brAddr in the same cycle
`default_nettype none

module memoryStage import isaPkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [31:0]             brRData,
    pipeLink.dst                    exMem,
    output logic [31:0]             brPc,
    output logic [31:0]             brAddr,
    output logic [31:0]             brWData,
    output logic [3:0]              brWe,
    output logic [regAddrWidth-1:0] wbAddr,
    output logic [31:0]             wbData,
    output logic                    wbWe
);
    logic        storeFwd;
    logic [31:0] wbNext;

    // Load right ahead of a store delivers its rt here
    assign storeFwd = wbWe && wbAddr != '0 && wbAddr == exMem.rtAddr;

    assign brPc = exMem.pc;
    assign brAddr = exMem.writeData;
    assign brWData = storeFwd ? wbData : exMem.rtData;
    assign brWe = exMem.isStore ? 4'hf : 4'h0;

    // Writeback select
    assign wbNext = exMem.isLoad ? brRData : exMem.writeData;

    always_ff @(posedge clk) begin
        if (reset) begin
            wbWe <= 1'b0;
            wbAddr <= '0;
        end else begin
            wbWe <= exMem.writes;
            wbAddr <= exMem.writes ? exMem.writeAddr : '0;
        end
    end

    always_ff @(posedge clk) begin
        wbData <= wbNext;
    end

    storeAligned: assert property (@(posedge clk) disable iff (reset)
        brWe == 4'hf |-> brAddr[1:0] == 2'b00);
    quietAfterReset: assert property (@(posedge clk) reset |=> brWe == 4'h0);

endmodule

`default_nettype wire

// File: verilog/hazardUnit.sv
// Stalls decode only; producers are the execute and memory stages, Tuse is fixed per class
`default_nettype none

module hazardUnit import isaPkg::*, pipePkg::*; (
    input  logic                    clk,
    input  hazClassT                hazClass,
    input  logic [regAddrWidth-1:0] rsAddr,
    input  logic [regAddrWidth-1:0] rtAddr,
    pipeLink.dst                    idEx,
    pipeLink.dst                    exMem,
    output logic                    stall
);
    logic useRs;
    logic useRt;
    tnewT tuseRs;
    logic [1:0] tuseRt;
    logic rsLate;
    logic rtLate;

    always_comb begin
        useRs = 1'b0;
        useRt = 1'b0;
        tuseRs = 2'd0;
        tuseRt = 2'd0;
        case (hazClass)
            hzBranch: begin
                useRs = 1'b1;
                useRt = 1'b1;
            end
            hzAlu: begin
                useRs = 1'b1;
                useRt = 1'b1;
                tuseRs = 2'd1;
                tuseRt = 2'd1;
            end
            hzAluImm, hzLoad: begin
                useRs = 1'b1;
                tuseRs = 2'd1;
            end
            // Store data is needed only in memory
            hzStore: begin
                useRs = 1'b1;
                useRt = 1'b1;
                tuseRs = 2'd1;
                tuseRt = 2'd2;
            end
            default: useRs = 1'b0;
        endcase
    end

    // Late when the producer needs more cycles than the consumer can wait
    assign rsLate = useRs && rsAddr != '0 &&
        ((idEx.writeAddr == rsAddr && idEx.tnew > tuseRs) ||
         (exMem.writeAddr == rsAddr && exMem.tnew > tuseRs));
    assign rtLate = useRt && rtAddr != '0 &&
        ((idEx.writeAddr == rtAddr && idEx.tnew > tuseRt) ||
         (exMem.writeAddr == rtAddr && exMem.tnew > tuseRt));
    assign stall = rsLate || rtLate;

    // Two bubbles drain both producers, so a load into beq is the longest stall
    stallBounded: assert property (@(posedge clk)
        stall && $past(stall) |=> !stall);

endmodule

`default_nettype wire

// File: verilog/cpu.sv
// No coprocessor 0, exceptions, interrupts or multiply/divide; data bus is word-only
`default_nettype none

module cpu import isaPkg::*, pipePkg::*; #(
    parameter logic [31:0] resetPc = 32'h3000
) (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] pc,
    input  logic [31:0] instr,
    output logic [31:0] brPc,
    output logic [31:0] brAddr,
    output logic [31:0] brWData,
    output logic [3:0]  brWe,
    input  logic [31:0] brRData
);
    logic                    stall;
    logic                    branchTaken;
    logic [31:0]             branchTarget;
    logic [31:0]             idInstr;
    logic [31:0]             idPc;
    logic [regAddrWidth-1:0] ra1;
    logic [regAddrWidth-1:0] ra2;
    logic [31:0]             rd1;
    logic [31:0]             rd2;
    hazClassT                hazClass;
    logic [regAddrWidth-1:0] rsAddr;
    logic [regAddrWidth-1:0] rtAddr;
    logic [regAddrWidth-1:0] wbAddr;
    logic [31:0]             wbData;
    logic                    wbWe;

    // Decode to execute and execute to memory
    pipeLink idEx ();
    pipeLink exMem ();

    fetchStage #(.resetPc(resetPc)) fetch (
        .clk(clk), .reset(reset), .stall(stall),
        .branchTaken(branchTaken), .branchTarget(branchTarget), .instr(instr),
        .pc(pc), .idInstr(idInstr), .idPc(idPc)
    );

    decodeStage decode (
        .clk(clk), .reset(reset), .stall(stall),
        .idInstr(idInstr), .idPc(idPc), .rd1(rd1), .rd2(rd2),
        .ra1(ra1), .ra2(ra2), .branchTaken(branchTaken), .branchTarget(branchTarget),
        .hazClass(hazClass), .rsAddr(rsAddr), .rtAddr(rtAddr),
        .idEx(idEx.src), .exMem(exMem.dst)
    );

    regFile regs (
        .clk(clk), .reset(reset), .ra1(ra1), .ra2(ra2),
        .we(wbWe), .wa(wbAddr), .wd(wbData), .rd1(rd1), .rd2(rd2)
    );

    executeStage execute (
        .clk(clk), .reset(reset), .wbAddr(wbAddr), .wbData(wbData),
        .idEx(idEx.dst), .exMem(exMem.src)
    );

    memoryStage memory (
        .clk(clk), .reset(reset), .brRData(brRData), .exMem(exMem.dst),
        .brPc(brPc), .brAddr(brAddr), .brWData(brWData), .brWe(brWe),
        .wbAddr(wbAddr), .wbData(wbData), .wbWe(wbWe)
    );

    hazardUnit hazard (
        .clk(clk), .hazClass(hazClass), .rsAddr(rsAddr), .rtAddr(rtAddr),
        .idEx(idEx.dst), .exMem(exMem.dst), .stall(stall)
    );

endmodule

`default_nettype wire

// File: sim/cpuTb.sv
// Program is built in; data memory covers only byte addresses below 4096, word access only
`default_nettype none

module cpuTb import isaPkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] resetPc = 32'h3000;
    localparam int clkPeriod = 100;
    localparam int driveDelay = 5;
    localparam int resetCycles = 8;
    localparam int progLen = 32;
    localparam int expCount = 11;
    localparam int memWords = 1024;
    localparam int randomSeed = 27658;
    localparam int timeoutCycles = resetCycles + progLen * 20;
    // A few cycles past the last instruction so the pipeline drains
    localparam logic [31:0] endPc = resetPc + 32'(4 * (progLen + 6));

    logic        clk;
    logic        reset;
    logic [31:0] pc;
    logic [31:0] instr;
    logic [31:0] brPc;
    logic [31:0] brAddr;
    logic [31:0] brWData;
    logic [3:0]  brWe;
    logic [31:0] brRData;

    logic [31:0] rom [progLen];
    logic [31:0] dataMem [memWords];
    logic [31:0] expPc [expCount];
    logic [31:0] expAddr [expCount];
    logic [31:0] expData [expCount];
    logic [31:0] romIndex;
    int          storeIndex;
    int          checkCount;
    int          errorCount;

    cpu #(.resetPc(resetPc)) UUT (
        .clk(clk), .reset(reset), .pc(pc), .instr(instr),
        .brPc(brPc), .brAddr(brAddr), .brWData(brWData), .brWe(brWe),
        .brRData(brRData)
    );

    initial clk = 1'b0;
    always #(clkPeriod / 2) clk = ~clk;

    // Instruction ROM, nop outside the program
    assign romIndex = (pc - resetPc) >> 2;
    assign instr = (romIndex < progLen) ? rom[romIndex[4:0]] : 32'h0000_0000;

    assign brRData = dataMem[brAddr[11:2]];

    function automatic logic [31:0] rTypeWord(functT fn, logic [4:0] rs, logic [4:0] rt,
                                              logic [4:0] rd);
        return {opSpecial, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iTypeWord(opcodeT op, logic [4:0] rs, logic [4:0] rt,
                                              logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Offset counts words from the delay slot
    function automatic logic [31:0] beqWord(logic [4:0] rs, logic [4:0] rt, int from, int to);
        logic [15:0] offset;
        offset = 16'(to - from - 1);
        return {opBeq, rs, rt, offset};
    endfunction

    function automatic logic [31:0] jumpWord(int to);
        logic [31:0] target;
        target = resetPc + 32'(4 * to);
        return {opJ, target[27:2]};
    endfunction

    task automatic buildProgram();
        for (int i = 0; i < progLen; i++) begin
            rom[i] = 32'h0000_0000;
        end
        // ALU chains with forwarding from memory and writeback
        rom[0]  = iTypeWord(opLui, 5'd0, 5'd1, 16'h1234);
        rom[1]  = iTypeWord(opOri, 5'd1, 5'd1, 16'h5678);
        rom[2]  = iTypeWord(opLui, 5'd0, 5'd2, 16'h0001);
        rom[3]  = rTypeWord(fnAddu, 5'd1, 5'd2, 5'd3);
        rom[4]  = rTypeWord(fnSubu, 5'd3, 5'd1, 5'd4);
        rom[5]  = iTypeWord(opSw, 5'd0, 5'd3, 16'h0100);
        rom[6]  = iTypeWord(opSw, 5'd0, 5'd4, 16'h0104);
        rom[7]  = iTypeWord(opOri, 5'd0, 5'd5, 16'h00ff);
        rom[8]  = rTypeWord(fnAddu, 5'd5, 5'd5, 5'd6);
        rom[9]  = iTypeWord(opSw, 5'd0, 5'd6, 16'h0108);
        rom[10] = iTypeWord(opSw, 5'd0, 5'd1, 16'h010c);
        // Load-use stall and store data from writeback
        rom[11] = iTypeWord(opLw, 5'd0, 5'd7, 16'h0200);
        rom[12] = rTypeWord(fnAddu, 5'd7, 5'd5, 5'd8);
        rom[13] = iTypeWord(opSw, 5'd0, 5'd8, 16'h0110);
        rom[14] = iTypeWord(opLw, 5'd0, 5'd9, 16'h0204);
        rom[15] = iTypeWord(opSw, 5'd0, 5'd9, 16'h0114);
        // Not-taken beq on a fresh result
        rom[16] = iTypeWord(opOri, 5'd0, 5'd10, 16'h0005);
        rom[17] = beqWord(5'd10, 5'd0, 17, 20);
        rom[18] = iTypeWord(opSw, 5'd0, 5'd10, 16'h0118);
        rom[19] = iTypeWord(opOri, 5'd0, 5'd11, 16'h00aa);
        rom[20] = iTypeWord(opSw, 5'd0, 5'd11, 16'h011c);
        // Taken beq, two stores skipped
        rom[21] = rTypeWord(fnSubu, 5'd10, 5'd0, 5'd12);
        rom[22] = beqWord(5'd12, 5'd10, 22, 26);
        rom[23] = iTypeWord(opSw, 5'd0, 5'd11, 16'h0120);
        rom[24] = iTypeWord(opSw, 5'd0, 5'd10, 16'h0124);
        rom[25] = iTypeWord(opSw, 5'd0, 5'd10, 16'h0128);
        rom[26] = jumpWord(29);
        rom[27] = iTypeWord(opSw, 5'd0, 5'd5, 16'h012c);
        rom[28] = iTypeWord(opSw, 5'd0, 5'd5, 16'h0130);
        rom[29] = iTypeWord(opOri, 5'd0, 5'd13, 16'h0777);
        rom[30] = iTypeWord(opSw, 5'd0, 5'd13, 16'h0134);
    endtask

    // Slot is the ROM index of the store, which sets its brPc
    task automatic setExpected(int i, int slot, logic [31:0] addr, logic [31:0] data);
        expPc[i] = resetPc + 32'(4 * slot);
        expAddr[i] = addr;
        expData[i] = data;
    endtask

    // Register values worked out from the instruction rules, stores in program order
    task automatic buildExpected();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        logic [31:0] r4;
        logic [31:0] r5;
        logic [31:0] r6;
        logic [31:0] r8;
        logic [31:0] r9;
        r1 = {16'h1234, 16'h0000} | {16'h0000, 16'h5678};
        r2 = {16'h0001, 16'h0000};
        r3 = r1 + r2;
        r4 = r3 - r1;
        r5 = 32'h0000_00ff;
        r6 = r5 + r5;
        r8 = dataMem[32'h200 >> 2] + r5;
        r9 = dataMem[32'h204 >> 2];
        setExpected(0, 5, 32'h100, r3);
        setExpected(1, 6, 32'h104, r4);
        setExpected(2, 9, 32'h108, r6);
        setExpected(3, 10, 32'h10c, r1);
        setExpected(4, 13, 32'h110, r8);
        setExpected(5, 15, 32'h114, r9);
        setExpected(6, 18, 32'h118, 32'h0000_0005);
        setExpected(7, 20, 32'h11c, 32'h0000_00aa);
        // Delay slots of the taken beq and of j
        setExpected(8, 23, 32'h120, 32'h0000_00aa);
        setExpected(9, 27, 32'h12c, r5);
        setExpected(10, 30, 32'h134, 32'h0000_0777);
    endtask

    task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERROR at %t: %s is 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic finishRun();
        $display("Checks: %0d, errors: %0d, stores seen: %0d of %0d",
                 checkCount, errorCount, storeIndex, expCount);
        if (errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // Bus is stable at the falling edge
    always @(negedge clk) begin
        if (brWe != 4'h0) begin
            if (storeIndex < expCount) begin
                checkValue("brWe", {28'h0, brWe}, 32'h0000_000f);
                checkValue("brPc", brPc, expPc[storeIndex]);
                checkValue("brAddr", brAddr, expAddr[storeIndex]);
                checkValue("brWData", brWData, expData[storeIndex]);
            end else begin
                errorCount++;
                $display("Unexpected extra store of 0x%08h to address 0x%08h at %t",
                         brWData, brAddr, $time);
            end
            storeIndex++;
            dataMem[brAddr[11:2]] = brWData;
        end
    end

    initial begin
        $timeformat(-9, 1, " ns", 0);
        reset = 1'b1;
        storeIndex = 0;
        checkCount = 0;
        errorCount = 0;
        void'($urandom(randomSeed));
        for (int i = 0; i < memWords; i++) begin
            dataMem[i] = $urandom;
        end
        buildProgram();
        buildExpected();

        repeat (resetCycles) begin
            @(posedge clk);
            #driveDelay;
            checkValue("pc", pc, resetPc);
            checkValue("brWe", {28'h0, brWe}, 32'h0);
        end
        reset = 1'b0;
        // First cycle out of reset
        @(negedge clk);
        checkValue("pc", pc, resetPc);
        checkValue("brWe", {28'h0, brWe}, 32'h0);

        while (pc < endPc) begin
            @(negedge clk);
        end
        if (storeIndex < expCount) begin
            errorCount++;
            $display("Only %0d of %0d expected stores appeared", storeIndex, expCount);
        end
        finishRun();
    end

    initial begin
        #(timeoutCycles * clkPeriod);
        errorCount++;
        $display("Timeout, program did not finish within %0d clock cycles", timeoutCycles);
        finishRun();
    end

endmodule

`default_nettype wire

// File: files.f
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/pipeLink.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/regFile.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/hazardUnit.sv
verilog/cpu.sv
sim/cpuTb.sv

// File: runSim.sh
#!/bin/sh
# Builds the cpuTb testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
    --top-module cpuTb -f files.f -o cpuTbSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/cpuTbSim)
runStatus=$?
echo "$output"
if [ $runStatus -ne 0 ]; then
    echo "Simulator exited with status $runStatus"
    exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1
